// ==== rtl/board_pkg.sv ====
// shared map for the 16-bit board block; ram below 0x4000, one 256-byte register page at 0xff00
package board_pkg;

   // bus geometry
   parameter int DATA_W = 16;                // wishbone data width
   parameter int ADDR_W = 16;                // byte address width

   // address map
   parameter logic [ADDR_W-1:0] RAM_LIMIT = 16'h4000;   // first byte above the ram
   parameter logic [ADDR_W-1:0] IO_BASE   = 16'hFF00;   // register page base

   // register byte offsets inside the io page
   parameter logic [7:0] REG_SEG_LO = 8'h00;   // digit 1 : digit 0
   parameter logic [7:0] REG_SEG_HI = 8'h02;   // digit 3 : digit 2
   parameter logic [7:0] REG_LED    = 8'h04;   // bits 3..0 only
   parameter logic [7:0] REG_STATUS = 8'h06;   // read only, toggle levels

   // one-hot target select bit positions
   parameter int SEL_RAM  = 0;
   parameter int SEL_IO   = 1;
   parameter int SEL_NONE = 2;

   // seven-segment scanner
   parameter int SCAN_POS = 6;               // digit positions on the board

endpackage

// ==== rtl/wb_addr_decode.sv ====
// select is all zero while cyc is low; page offsets 8 and up decode as unmapped
`timescale 1ns/10ps

module wb_addr_decode
(
   input  logic [board_pkg::ADDR_W-1:0] adr_i,  // byte address from the master
   input  logic                         cyc_i,
   input  logic                         stb_i,
   output logic [2:0]                   sel_o,  // one-hot target
   output logic                         ram_stb_o,
   output logic                         io_stb_o
);

   logic hit_ram;   // below ram limit
   logic hit_io;    // defined register in the io page

   assign hit_ram = adr_i < board_pkg::RAM_LIMIT;

   // page match on the upper byte, defined offsets are 0..7
   assign hit_io = (adr_i[15:8] == board_pkg::IO_BASE[15:8])
                 & (adr_i[7:3] == 5'd0);

   always_comb
   begin
      sel_o = 3'b000;
      if (cyc_i)
      begin
         if (hit_ram)
            sel_o[board_pkg::SEL_RAM] = 1'b1;
         else if (hit_io)
            sel_o[board_pkg::SEL_IO] = 1'b1;
         else
            sel_o[board_pkg::SEL_NONE] = 1'b1;   // unmapped, acked by the mux
      end
   end

   // per-target strobes, cyc already folded into sel
   assign ram_stb_o = stb_i & sel_o[board_pkg::SEL_RAM];
   assign io_stb_o  = stb_i & sel_o[board_pkg::SEL_IO];

endmodule

// ==== rtl/wb_ram.sv ====
// block ram, contents undefined after power-up; reads take two wait states, writes none
`timescale 1ns/10ps

module wb_ram
#(
   parameter int AW = 13                            // word address width
)
(
   input  logic                         sys_clk_p,
   input  logic                         rst_i,
   input  logic [AW-1:0]                adr_i,      // word address
   input  logic [board_pkg::DATA_W-1:0] dat_i,
   input  logic                         we_i,
   input  logic [1:0]                   sel_i,      // byte enables
   input  logic                         stb_i,      // already qualified by cyc
   output logic [board_pkg::DATA_W-1:0] dat_o,
   output logic                         ack_o
);

   logic [board_pkg::DATA_W-1:0] mem [2**AW];
   logic [1:0]                   rd_pipe;    // read strobe delay line

   // storage, byte lanes written separately
   always_ff @(posedge sys_clk_p)
   begin
      if (stb_i & we_i)
      begin
         if (sel_i[0])
            mem[adr_i][7:0] <= dat_i[7:0];
         if (sel_i[1])
            mem[adr_i][15:8] <= dat_i[15:8];
      end
      dat_o <= mem[adr_i];   // free-running read port
   end

   // two-stage read acknowledge
   always_ff @(posedge sys_clk_p)
   begin
      if (rst_i)
         rd_pipe <= 2'b00;
      else
      begin
         rd_pipe[0] <= stb_i & ~we_i;
         rd_pipe[1] <= stb_i & rd_pipe[0];   // drops as soon as stb goes away
      end
   end

   // write acks at once, read after the pipe fills
   assign ack_o = stb_i & (we_i | rd_pipe[1]);

endmodule

// ==== rtl/io_regs.sv ====
// registers reset to zero; status word is read only and writes to it are dropped
`timescale 1ns/10ps

module io_regs
(
   input  logic                         sys_clk_p,
   input  logic                         rst_i,
   input  logic [1:0]                   off_i,     // word offset in the page
   input  logic [board_pkg::DATA_W-1:0] dat_i,
   input  logic                         we_i,
   input  logic [1:0]                   sel_i,     // byte lanes
   input  logic                         stb_i,
   input  logic [1:0]                   tog_i,     // button toggle levels
   output logic [board_pkg::DATA_W-1:0] dat_o,
   output logic                         ack_o,
   output logic [3:0][7:0]              digit_o,   // raw segment patterns
   output logic [3:0]                   led_o
);

   logic [15:0] seg_lo;   // digits 1:0
   logic [15:0] seg_hi;   // digits 3:2
   logic [3:0]  led;
   logic        wr;

   assign wr = stb_i & we_i;

   always_ff @(posedge sys_clk_p)
   begin
      if (rst_i)
      begin
         seg_lo <= 16'h0000;
         seg_hi <= 16'h0000;
         led    <= 4'h0;
      end
      else if (wr)
      begin
         if (off_i == board_pkg::REG_SEG_LO[2:1])
         begin
            if (sel_i[0]) seg_lo[7:0]  <= dat_i[7:0];
            if (sel_i[1]) seg_lo[15:8] <= dat_i[15:8];
         end
         if (off_i == board_pkg::REG_SEG_HI[2:1])
         begin
            if (sel_i[0]) seg_hi[7:0]  <= dat_i[7:0];
            if (sel_i[1]) seg_hi[15:8] <= dat_i[15:8];
         end
         if ((off_i == board_pkg::REG_LED[2:1]) && sel_i[0])
            led <= dat_i[3:0];                   // upper lane has nothing to hold
      end
   end

   // read return, status assembled from live toggle levels
   always_comb
   begin
      case (off_i)
         board_pkg::REG_SEG_LO[2:1]: dat_o = seg_lo;
         board_pkg::REG_SEG_HI[2:1]: dat_o = seg_hi;
         board_pkg::REG_LED[2:1]:    dat_o = {12'h000, led};
         board_pkg::REG_STATUS[2:1]: dat_o = {14'h0000, tog_i};
         default:                    dat_o = 16'h0000;
      endcase
   end

   assign ack_o   = stb_i;   // zero wait states
   assign digit_o = {seg_hi[15:8], seg_hi[7:0], seg_lo[15:8], seg_lo[7:0]};
   assign led_o   = led;

endmodule

// ==== rtl/tick_gen.sv ====
// strobes are registered one-cycle pulses; both parameters must be at least 1
`timescale 1ns/10ps

module tick_gen
#(
   parameter int CLK_MHZ   = 50,     // clocks per microsecond
   parameter int US_PER_MS = 1000    // microseconds per millisecond
)
(
   input  logic sys_clk_p,
   input  logic rst_i,
   output logic us_stb_o,
   output logic ms_stb_o
);

   localparam int UW = $clog2(CLK_MHZ + 1);
   localparam int MW = $clog2(US_PER_MS + 1);

   logic [UW-1:0] us_cnt;
   logic [MW-1:0] ms_cnt;
   logic          us_tc;    // last clock of the microsecond
   logic          ms_tc;    // last microsecond of the millisecond

   assign us_tc = us_cnt == '0;
   assign ms_tc = ms_cnt == '0;

   always_ff @(posedge sys_clk_p)
   begin
      if (rst_i)
      begin
         us_cnt   <= UW'(CLK_MHZ - 1);
         ms_cnt   <= MW'(US_PER_MS - 1);
         us_stb_o <= 1'b0;
         ms_stb_o <= 1'b0;
      end
      else
      begin
         us_stb_o <= us_tc;
         ms_stb_o <= us_tc & ms_tc;
         us_cnt   <= us_tc ? UW'(CLK_MHZ - 1) : us_cnt - 1'b1;
         if (us_tc)
            ms_cnt <= ms_tc ? MW'(US_PER_MS - 1) : ms_cnt - 1'b1;  // steps once per us
      end
   end

endmodule

// ==== rtl/btn_toggle.sv ====
// button is sampled only on ms_stb with no extra synchronizer; needs a quiet input near the edge
`timescale 1ns/10ps

module btn_toggle
(
   input  logic sys_clk_p,
   input  logic rst_i,
   input  logic btn_n_i,    // active low push button
   input  logic ms_stb_i,   // sample enable
   output logic level_o
);

   logic smp;   // button state at the previous ms strobe
   logic press;

   // press means high at the last sample and low now
   assign press = ms_stb_i & smp & ~btn_n_i;

   always_ff @(posedge sys_clk_p)
   begin
      if (rst_i)
      begin
         smp     <= 1'b0;   // no press until a released sample is seen
         level_o <= 1'b0;
      end
      else
      begin
         if (ms_stb_i)
            smp <= btn_n_i;
         if (press)
            level_o <= ~level_o;
      end
   end

endmodule

// ==== rtl/seg_scan.sv ====
// common-anode style display, all outputs active low; positions 4 and 5 stay blank
`timescale 1ns/10ps

module seg_scan
(
   input  logic            sys_clk_p,
   input  logic            rst_i,
   input  logic            ms_stb_i,
   input  logic [3:0][7:0] digit_i,   // segment patterns for positions 0..3
   output logic [7:0]      hex_o,
   output logic [5:0]      hsel_o
);

   logic [2:0] pos;
   logic [2:0] pos_nxt;   // position after this strobe
   logic [2:0] pos_cur;   // position the outputs show next cycle

   // counts down, wrapping 0 -> 5
   assign pos_nxt = (pos == 3'd0) ? 3'(board_pkg::SCAN_POS - 1) : pos - 3'd1;
   assign pos_cur = ms_stb_i ? pos_nxt : pos;

   always_ff @(posedge sys_clk_p)
   begin
      if (rst_i)
      begin
         pos    <= 3'd0;
         hsel_o <= 6'b111110;
         hex_o  <= 8'hFF;
      end
      else
      begin
         if (ms_stb_i)
            pos <= pos_nxt;
         hsel_o <= ~(6'b000001 << pos_cur);
         if (pos_cur < 3'd4)
            hex_o <= ~digit_i[pos_cur[1:0]];   // tracks register writes too
         else
            hex_o <= 8'hFF;
      end
   end

endmodule

// ==== rtl/wb_read_mux.sv ====
// select must be one-hot or zero; zero select returns no ack
`timescale 1ns/10ps

module wb_read_mux
(
   input  logic [2:0]                   sel_i,
   input  logic                         stb_i,
   input  logic [board_pkg::DATA_W-1:0] ram_dat_i,
   input  logic                         ram_ack_i,
   input  logic [board_pkg::DATA_W-1:0] io_dat_i,
   input  logic                         io_ack_i,
   output logic [board_pkg::DATA_W-1:0] dat_o,
   output logic                         ack_o
);

   always_comb
   begin
      dat_o = '0;   // unmapped reads return zero
      if (sel_i[board_pkg::SEL_RAM])
         dat_o = ram_dat_i;
      else if (sel_i[board_pkg::SEL_IO])
         dat_o = io_dat_i;
   end

   // unmapped target acks in the same cycle
   assign ack_o = (sel_i[board_pkg::SEL_RAM]  & ram_ack_i)
                | (sel_i[board_pkg::SEL_IO]   & io_ack_i)
                | (sel_i[board_pkg::SEL_NONE] & stb_i);

endmodule

// ==== rtl/board_top.sv ====
// classic wishbone slave; master holds stb until ack and drops it for a cycle after
`timescale 1ns/10ps

module board_top
#(
   parameter int CLK_MHZ   = 50,
   parameter int US_PER_MS = 1000
)
(
   input  logic                         sys_clk_p,
   input  logic                         rst_i,
   input  logic [board_pkg::ADDR_W-1:0] wb_adr_i,
   input  logic [board_pkg::DATA_W-1:0] wb_dat_i,
   output logic [board_pkg::DATA_W-1:0] wb_dat_o,
   input  logic                         wb_cyc_i,
   input  logic                         wb_stb_i,
   input  logic                         wb_we_i,
   input  logic [1:0]                   wb_sel_i,
   output logic                         wb_ack_o,
   input  logic [1:0]                   button_n_i,   // active low push buttons
   output logic [3:0]                   led_o,
   output logic [7:0]                   hex_o,        // active low segments
   output logic [5:0]                   hsel_o        // active low digit select
);

   logic [2:0]                   sel;
   logic                         ram_stb;
   logic                         io_stb;
   logic [board_pkg::DATA_W-1:0] ram_dat;
   logic [board_pkg::DATA_W-1:0] io_dat;
   logic                         ram_ack;
   logic                         io_ack;
   logic                         ms_stb;
   logic [1:0]                   tog;        // button toggle levels
   logic [3:0][7:0]              digit;      // display patterns

   wb_addr_decode u_dec
   (
      .adr_i     (wb_adr_i),
      .cyc_i     (wb_cyc_i),
      .stb_i     (wb_stb_i),
      .sel_o     (sel),
      .ram_stb_o (ram_stb),
      .io_stb_o  (io_stb)
   );

   wb_ram #(.AW(13)) u_ram
   (
      .sys_clk_p (sys_clk_p),
      .rst_i     (rst_i),
      .adr_i     (wb_adr_i[13:1]),   // word address
      .dat_i     (wb_dat_i),
      .we_i      (wb_we_i),
      .sel_i     (wb_sel_i),
      .stb_i     (ram_stb),
      .dat_o     (ram_dat),
      .ack_o     (ram_ack)
   );

   io_regs u_regs
   (
      .sys_clk_p (sys_clk_p),
      .rst_i     (rst_i),
      .off_i     (wb_adr_i[2:1]),
      .dat_i     (wb_dat_i),
      .we_i      (wb_we_i),
      .sel_i     (wb_sel_i),
      .stb_i     (io_stb),
      .tog_i     (tog),
      .dat_o     (io_dat),
      .ack_o     (io_ack),
      .digit_o   (digit),
      .led_o     (led_o)
   );

   tick_gen #(.CLK_MHZ(CLK_MHZ), .US_PER_MS(US_PER_MS)) u_tick
   (
      .sys_clk_p (sys_clk_p),
      .rst_i     (rst_i),
      .us_stb_o  (),
      .ms_stb_o  (ms_stb)
   );

   btn_toggle u_tog0
   (
      .sys_clk_p (sys_clk_p),
      .rst_i     (rst_i),
      .btn_n_i   (button_n_i[0]),
      .ms_stb_i  (ms_stb),
      .level_o   (tog[0])
   );

   btn_toggle u_tog1
   (
      .sys_clk_p (sys_clk_p),
      .rst_i     (rst_i),
      .btn_n_i   (button_n_i[1]),
      .ms_stb_i  (ms_stb),
      .level_o   (tog[1])
   );

   seg_scan u_scan
   (
      .sys_clk_p (sys_clk_p),
      .rst_i     (rst_i),
      .ms_stb_i  (ms_stb),
      .digit_i   (digit),
      .hex_o     (hex_o),
      .hsel_o    (hsel_o)
   );

   wb_read_mux u_mux
   (
      .sel_i     (sel),
      .stb_i     (wb_stb_i),
      .ram_dat_i (ram_dat),
      .ram_ack_i (ram_ack),
      .io_dat_i  (io_dat),
      .io_ack_i  (io_ack),
      .dat_o     (wb_dat_o),
      .ack_o     (wb_ack_o)
   );

endmodule

// ==== tests/board_checker.sv ====
// samples on the rising edge, so dut inputs must move on the falling edge; ram words are read only after a write
`timescale 1ns/10ps

module board_checker
#(
   parameter int MS_CYC = 8                    // clocks between ms strobes
)
(
   input  logic        sys_clk_p,
   input  logic        rst_i,
   input  logic [15:0] wb_adr_i,
   input  logic [15:0] wb_dat_i,
   input  logic [15:0] wb_dat_o,
   input  logic        wb_cyc_i,
   input  logic        wb_stb_i,
   input  logic        wb_we_i,
   input  logic [1:0]  wb_sel_i,
   input  logic        wb_ack_o,
   input  logic [1:0]  button_n_i,
   input  logic [3:0]  led_o,
   input  logic [7:0]  hex_o,
   input  logic [5:0]  hsel_o,
   output int          errors_o,
   output int          checks_o
);

   logic [15:0]     ram_m [int];   // sparse word model
   logic [15:0]     seg_m [2];     // seg lo, seg hi
   logic [3:0]      led_m;
   logic [1:0]      tog_m;         // press parity per button
   logic [1:0]      btn_prev;
   logic [3:0][7:0] dig_prev;      // digits behind the hex_o now showing
   logic [5:0]      hsel_prev;
   logic [5:0]      exp_sel;
   logic [7:0]      exp_hex;
   logic            exp_ack;
   logic            stepped;       // first scan step after reset seen
   int              scan_pos;
   int              stall;         // cycles since the last scan step
   int              age;           // cycles stb has been high
   int              tgt;
   int              word;
   int              err_cnt = 0;
   int              chk_cnt = 0;

   assign errors_o = err_cnt;
   assign checks_o = chk_cnt;

   function automatic logic [15:0] merge_bytes(input logic [15:0] old, input logic [15:0] nw,
                                               input logic [1:0] sel);
      merge_bytes = old;
      if (sel[0])
         merge_bytes[7:0] = nw[7:0];
      if (sel[1])
         merge_bytes[15:8] = nw[15:8];
   endfunction

   // address map as the bus sees it
   function automatic int target_of(input logic [15:0] adr);
      if (adr < board_pkg::RAM_LIMIT)
         return board_pkg::SEL_RAM;
      if ((adr[15:8] == board_pkg::IO_BASE[15:8]) && (adr[7:0] < 8'h08))
         return board_pkg::SEL_IO;
      return board_pkg::SEL_NONE;
   endfunction

   function automatic logic [15:0] reg_value(input logic [7:0] off);
      case (off)
         board_pkg::REG_SEG_LO: return seg_m[0];
         board_pkg::REG_SEG_HI: return seg_m[1];
         board_pkg::REG_LED:    return {12'h000, led_m};
         board_pkg::REG_STATUS: return {14'd0, tog_m};
         default:               return 16'h0000;
      endcase
   endfunction

   task automatic compare(input string name, input logic [15:0] exp, input logic [15:0] got);
      chk_cnt++;
      if (exp !== got)
      begin
         err_cnt++;
         $display("[ERROR] %s exp %h got %h at %0t", name, exp, got, $time);
      end
   endtask

   always @(posedge sys_clk_p)
   begin
      if (rst_i)
      begin
         seg_m[0]  = 16'h0000;
         seg_m[1]  = 16'h0000;
         led_m     = 4'h0;
         tog_m     = 2'b00;
         btn_prev  = 2'b00;   // no press before a released sample
         dig_prev  = '0;
         hsel_prev = 6'b111110;
         stepped   = 1'b0;
         scan_pos  = 0;
         stall     = 0;
         age       = 0;
      end
      else
      begin
         // scanner steps 0,5,4,3,2,1 on every select change
         if (hsel_o != hsel_prev)
         begin
            if (stepped && (stall != MS_CYC - 1))   // one step per ms strobe
            begin
               err_cnt++;
               $display("scanner stepped %0d cycles after the last step instead of %0d at %0t",
                        stall + 1, MS_CYC, $time);
            end
            scan_pos = (scan_pos == 0) ? 5 : scan_pos - 1;
            stall    = 0;
            stepped  = 1'b1;
         end
         else
            stall++;
         if (stall > 2 * MS_CYC)
         begin
            err_cnt++;
            $display("scanner made no step for %0d cycles at %0t", stall, $time);
            stall = 0;
         end
         exp_sel = ~(6'b000001 << scan_pos);
         exp_hex = (scan_pos < 4) ? ~dig_prev[scan_pos] : 8'hFF;   // blank on 4 and 5
         compare("hsel_o", {10'd0, exp_sel}, {10'd0, hsel_o});
         compare("hex_o", {8'd0, exp_hex}, {8'd0, hex_o});
         compare("led_o", {12'd0, led_m}, {12'd0, led_o});
         hsel_prev = hsel_o;
         dig_prev  = {seg_m[1], seg_m[0]};   // hex_o lags the registers by one edge

         // toggles flip on a released-to-pressed change
         tog_m    = tog_m ^ (btn_prev & ~button_n_i);
         btn_prev = button_n_i;

         if (wb_cyc_i && wb_stb_i)
         begin
            tgt     = target_of(wb_adr_i);
            exp_ack = (tgt == board_pkg::SEL_RAM && !wb_we_i) ? (age == 2) : (age == 0);
            compare("wb_ack_o", {15'd0, exp_ack}, {15'd0, wb_ack_o});
            word = int'(wb_adr_i[13:1]);
            if (wb_ack_o && exp_ack)
            begin
               if (wb_we_i && tgt == board_pkg::SEL_RAM)
                  ram_m[word] = merge_bytes(ram_m[word], wb_dat_i, wb_sel_i);
               else if (wb_we_i && tgt == board_pkg::SEL_IO)
               begin
                  case (wb_adr_i[7:0])
                     board_pkg::REG_SEG_LO: seg_m[0] = merge_bytes(seg_m[0], wb_dat_i, wb_sel_i);
                     board_pkg::REG_SEG_HI: seg_m[1] = merge_bytes(seg_m[1], wb_dat_i, wb_sel_i);
                     board_pkg::REG_LED:
                        if (wb_sel_i[0])
                           led_m = wb_dat_i[3:0];
                     default: ;   // status is read only
                  endcase
               end
               else if (!wb_we_i && tgt == board_pkg::SEL_RAM)
                  compare($sformatf("wb_dat_o ram %h", wb_adr_i), ram_m[word], wb_dat_o);
               else if (!wb_we_i && tgt == board_pkg::SEL_IO)
                  compare($sformatf("wb_dat_o reg %h", wb_adr_i), reg_value(wb_adr_i[7:0]),
                          wb_dat_o);
               else if (!wb_we_i)
                  compare($sformatf("wb_dat_o unmapped %h", wb_adr_i), 16'h0000, wb_dat_o);
            end
            age++;
         end
         else
         begin
            compare("wb_ack_o", 16'h0000, {15'd0, wb_ack_o});   // idle bus
            age = 0;
         end
      end
   end

endmodule

// ==== tests/tb_board.sv ====
// bus master and button driver for board_top; all comparing is done in board_checker
`timescale 1ns/10ps

module tb_board;

   localparam int CLK_MHZ   = 2;
   localparam int US_PER_MS = 4;
   localparam int MS_CYC    = CLK_MHZ * US_PER_MS;   // ms strobe every 8 clocks
   localparam int N_RAM     = 16;                    // ram words in use
   localparam int N_PART    = 48;                    // byte-select writes
   localparam int N_REG     = 24;
   localparam int N_UNMAP   = 12;
   localparam int N_OPS     = 1 + 3 * N_RAM + N_PART + 2 * N_REG + N_UNMAP + 4;
   localparam int BTN_PATS  = 12;
   localparam int HOLD_CYC  = 3 * MS_CYC;            // each pattern held 3 ms
   localparam int WATCH_CYC = 10 + N_OPS * 10 + BTN_PATS * (HOLD_CYC + 10) + 200;

   logic        sys_clk_p;
   logic        rst_i;
   logic [15:0] wb_adr;
   logic [15:0] wb_wdat;
   logic [15:0] wb_rdat;
   logic        wb_cyc;
   logic        wb_stb;
   logic        wb_we;
   logic [1:0]  wb_sel;
   logic        wb_ack;
   logic [1:0]  button_n;
   logic [3:0]  led;
   logic [7:0]  hex;
   logic [5:0]  hsel;
   logic [31:0] lfsr;
   logic [31:0] r;
   logic [31:0] d;
   logic [15:0] adr;
   logic [15:0] ram_adr [N_RAM];
   int          errors;
   int          checks;

   board_top #(.CLK_MHZ(CLK_MHZ), .US_PER_MS(US_PER_MS)) dut
   (
      .sys_clk_p (sys_clk_p), .rst_i (rst_i),
      .wb_adr_i (wb_adr), .wb_dat_i (wb_wdat), .wb_dat_o (wb_rdat),
      .wb_cyc_i (wb_cyc), .wb_stb_i (wb_stb), .wb_we_i (wb_we),
      .wb_sel_i (wb_sel), .wb_ack_o (wb_ack), .button_n_i (button_n),
      .led_o (led), .hex_o (hex), .hsel_o (hsel)
   );

   board_checker #(.MS_CYC(MS_CYC)) u_check
   (
      .sys_clk_p (sys_clk_p), .rst_i (rst_i),
      .wb_adr_i (wb_adr), .wb_dat_i (wb_wdat), .wb_dat_o (wb_rdat),
      .wb_cyc_i (wb_cyc), .wb_stb_i (wb_stb), .wb_we_i (wb_we),
      .wb_sel_i (wb_sel), .wb_ack_o (wb_ack), .button_n_i (button_n),
      .led_o (led), .hex_o (hex), .hsel_o (hsel),
      .errors_o (errors), .checks_o (checks)
   );

   always #50 sys_clk_p = ~sys_clk_p;   // 100 ns period

   // galois form, x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
   endfunction

   task automatic draw(input int n, output logic [31:0] v);
      v = '0;
      for (int i = 0; i < n; i++)
      begin
         lfsr = lfsr_step(lfsr);   // one step per bit
         v    = {v[30:0], lfsr[0]};
      end
   endtask

   function automatic logic [15:0] io_adr(input logic [7:0] off);
      return {board_pkg::IO_BASE[15:8], off};
   endfunction

   // one classic cycle, stb held until ack then dropped
   task automatic bus_cycle(input logic we, input logic [15:0] a, input logic [15:0] dat,
                            input logic [1:0] sel);
      @(negedge sys_clk_p);
      wb_adr  = a;
      wb_wdat = dat;
      wb_sel  = sel;
      wb_we   = we;
      wb_cyc  = 1'b1;
      wb_stb  = 1'b1;
      @(posedge sys_clk_p);
      while (!wb_ack)
         @(posedge sys_clk_p);
      @(negedge sys_clk_p);
      wb_stb = 1'b0;
      wb_cyc = 1'b0;
      wb_we  = 1'b0;
   endtask

   initial
   begin
      #(WATCH_CYC * 100);
      $display("watchdog expired after %0d cycles, bus or test sequence stuck", WATCH_CYC);
      $display("Test failed");
      $finish;
   end

   initial
   begin
      sys_clk_p = 1'b0;
      rst_i     = 1'b1;
      wb_adr    = 16'h0000;
      wb_wdat   = 16'h0000;
      wb_cyc    = 1'b0;
      wb_stb    = 1'b0;
      wb_we     = 1'b0;
      wb_sel    = 2'b00;
      button_n  = 2'b11;   // released
      lfsr      = 32'h0d42_87d1;
      repeat (10) @(posedge sys_clk_p);
      @(negedge sys_clk_p);
      rst_i = 1'b0;

      bus_cycle(1'b0, io_adr(board_pkg::REG_STATUS), 16'h0000, 2'b11);   // toggles clear

      // ram words first filled whole, then hit with byte selects
      for (int i = 0; i < N_RAM; i++)
      begin
         draw(29, r);
         ram_adr[i] = {2'b00, r[28:16], 1'b0};
         bus_cycle(1'b1, ram_adr[i], r[15:0], 2'b11);
      end
      for (int i = 0; i < N_PART; i++)
      begin
         draw(22, r);   // index, sel, data
         bus_cycle(1'b1, ram_adr[r[21:18]], r[15:0], r[17:16]);
      end
      for (int i = 0; i < N_RAM; i++)
         bus_cycle(1'b0, ram_adr[i], 16'h0000, 2'b11);

      // registers incl. writes to status, each read back
      for (int i = 0; i < N_REG; i++)
      begin
         draw(20, r);
         adr = io_adr({5'd0, r[19:18], 1'b0});
         bus_cycle(1'b1, adr, r[15:0], r[17:16]);
         bus_cycle(1'b0, adr, 16'h0000, 2'b11);
      end

      // gap between ram and page, or page offsets 8 and up
      for (int i = 0; i < N_UNMAP; i++)
      begin
         draw(18, r);
         draw(16, d);
         if (r[17])
            adr = 16'h4000 + (r[15:0] % 16'hBF00);
         else
            adr = {8'hFF, 8'h08 + (r[7:0] % 8'hF8)};
         adr[0] = 1'b0;
         bus_cycle(r[16], adr, d[15:0], 2'b11);
      end
      for (int i = 0; i < N_RAM; i++)
         bus_cycle(1'b0, ram_adr[i], 16'h0000, 2'b11);   // nothing disturbed
      for (int k = 0; k < 4; k++)
         bus_cycle(1'b0, io_adr(8'(2 * k)), 16'h0000, 2'b11);

      // button patterns, status read at the end of each hold
      for (int p = 0; p < BTN_PATS; p++)
      begin
         draw(2, r);
         @(negedge sys_clk_p);
         button_n = r[1:0];
         repeat (HOLD_CYC) @(posedge sys_clk_p);
         bus_cycle(1'b0, io_adr(board_pkg::REG_STATUS), 16'h0000, 2'b11);
      end

      repeat (4) @(posedge sys_clk_p);
      $display("checks %0d errors %0d", checks, errors);
      if (errors == 0)
         $display("Test completed successfully");
      else
         $display("Test failed");
      $finish;
   end

endmodule

// ==== sim.f ====
rtl/board_pkg.sv
rtl/wb_addr_decode.sv
rtl/wb_ram.sv
rtl/io_regs.sv
rtl/tick_gen.sv
rtl/btn_toggle.sv
rtl/seg_scan.sv
rtl/wb_read_mux.sv
rtl/board_top.sv
tests/board_checker.sv
tests/tb_board.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_board -f sim.f -o tb_board

out=$(./obj_dir/tb_board)
echo "$out"

if echo "$out" | grep -q "Test completed successfully"; then
   exit 0
else
   exit 1
fi
